//--- bench/tb_pwm_fault_monitor.sv
//==========================================================================
// testbench for the pwm gate-drive fault monitor
// directed tests against a reference event list, credit-paced consumer
//==========================================================================
`timescale 1ns/10ps

module tb_pwm_fault_monitor
    import pwm_fault_pkg::*;
();

    localparam int NUM_PHASES    = DEF_NUM_PHASES;
    localparam int MM_FILTER_CYC = DEF_MM_FILTER_CYC;
    localparam int MAX_CREDITS   = DEF_MAX_CREDITS;
    localparam int PH_W          = phase_idx_w(NUM_PHASES);
    localparam int NUM_SRC       = FAULT_KINDS * NUM_PHASES;
    localparam logic [31:0] SEED = 32'h349096cf;
    // longest wait for the expected records of one check
    localparam int RECORD_WAIT   = 200;
    // planned cycles per test, reset first
    localparam int RESET_CYC     = 20;
    localparam int T1_CYC        = 150;
    localparam int T2_CYC        = 150;
    localparam int T3_CYC        = 450;
    localparam int T4_CYC        = 100;
    localparam int T5_CYC        = 260;
    localparam int T6_CYC        = 1760;
    localparam int WATCHDOG_CYC  =
        2 * (RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC);

    logic                  i_clk;
    logic                  i_rst_n;
    logic [NUM_PHASES-1:0] pwm_dt;
    logic [NUM_PHASES-1:0] pwm_cmd;
    logic [NUM_PHASES-1:0] pwm_gate;
    logic                  evt_credit = 1'b0;
    logic                  fault_clr;
    logic                  evt_valid;
    logic [PH_W-1:0]       evt_phase;
    fault_kind_e           evt_kind;
    logic [NUM_SRC-1:0]    fault_status;

    // records as source index, phase * 2 + kind
    int          exp_q[$];
    int          rcv_q[$];
    int          exp_status;
    int          rcv_total = 0;
    int          crd_total = 0;
    int          crd_wait  = 0;
    logic [31:0] crd_state = SEED;
    logic [31:0] rng_state;
    logic        crd_en;
    logic        crd_random;

    pwm_fault_monitor u_dut (
        .i_pwm_dt       (pwm_dt),
        .i_pwm_cmd      (pwm_cmd),
        .i_pwm_gate     (pwm_gate),
        .i_evt_credit   (evt_credit),
        .i_fault_clr    (fault_clr),
        .o_evt_valid    (evt_valid),
        .o_evt_phase    (evt_phase),
        .o_evt_kind     (evt_kind),
        .o_fault_status (fault_status),
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    //======================================================================
    // helpers
    //======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("** Error [%s] expected %0d, actual %0d", name, expected, actual);
            abort_run("check failed");
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge i_clk);
        abort_run("watchdog: the tests did not finish within the planned time");
    end

    // record capture on the falling edge, away from DUT updates
    always @(negedge i_clk) begin
        if (i_rst_n && evt_valid) begin
            rcv_q.push_back(int'(evt_phase) * FAULT_KINDS + int'(evt_kind));
            rcv_total = rcv_total + 1;
            check_value("credit bound", 1, int'(rcv_total <= MAX_CREDITS + crd_total));
        end
    end

    // one credit back per received record, optionally after a random gap
    always @(posedge i_clk) begin
        evt_credit <= 1'b0;
        if (crd_wait > 0) begin
            crd_wait = crd_wait - 1;
        end else if (crd_en && (rcv_total > crd_total)) begin
            evt_credit <= 1'b1;
            crd_total = crd_total + 1;
            if (crd_random) begin
                crd_state = xorshift32(crd_state);
                crd_wait = int'(crd_state[2:0]);
            end
        end
    end

    task automatic expect_event(input int p, input int kind);
        exp_q.push_back(p * FAULT_KINDS + kind);
        exp_status = exp_status | (1 << (p * FAULT_KINDS + kind));
    endtask

    // dead-time line high for len cycles
    task automatic pulse_dead_time(input int p, input int len);
        @(posedge i_clk);
        pwm_dt[p] <= 1'b1;
        repeat (len) @(posedge i_clk);
        pwm_dt[p] <= 1'b0;
    endtask

    // command high while the gate stays low for len cycles
    task automatic hold_mismatch(input int p, input int len);
        @(posedge i_clk);
        pwm_cmd[p] <= 1'b1;
        repeat (len) @(posedge i_clk);
        pwm_cmd[p] <= 1'b0;
    endtask

    task automatic raise_fault(input int p, input int kind);
        if (kind == int'(FK_DEAD_TIME)) begin
            pulse_dead_time(p, 4);
        end else begin
            hold_mismatch(p, MM_FILTER_CYC + 3);
        end
        expect_event(p, kind);
    endtask

    task automatic compare_records(input string name);
        int waited;
        waited = 0;
        while (rcv_q.size() < exp_q.size() && waited < RECORD_WAIT) begin
            @(negedge i_clk);
            waited++;
        end
        // margin for a surplus record
        repeat (10) @(negedge i_clk);
        check_value({name, " record count"}, exp_q.size(), rcv_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value({name, " record src"}, exp_q[i], rcv_q[i]);
        end
        check_value({name, " status"}, exp_status, int'(fault_status));
        exp_q.delete();
        rcv_q.delete();
    endtask

    // all credits back in the DUT
    task automatic settle_credits(input string name);
        int waited;
        waited = 0;
        while (rcv_total > crd_total && waited < RECORD_WAIT) begin
            @(posedge i_clk);
            waited++;
        end
        repeat (3) @(posedge i_clk);
        check_value({name, " credits owed"}, 0, rcv_total - crd_total);
    endtask

    task automatic clear_status(input string name);
        @(posedge i_clk);
        fault_clr <= 1'b1;
        @(posedge i_clk);
        fault_clr <= 1'b0;
        exp_status = 0;
        @(negedge i_clk);
        check_value({name, " cleared"}, 0, int'(fault_status));
    endtask

    //======================================================================
    // tests
    //======================================================================
    task automatic test_reset_state();
        for (int i = 0; i < 20; i++) begin
            @(negedge i_clk);
            check_value("reset valid", 0, int'(evt_valid));
            check_value("reset status", 0, int'(fault_status));
        end
        // initial credits cover the first records
        crd_en = 1'b0;
        for (int i = 0; i < MAX_CREDITS; i++) begin
            raise_fault(i % NUM_PHASES, int'(FK_DEAD_TIME));
            repeat (12) @(posedge i_clk);
        end
        compare_records("reset credits");
        crd_en = 1'b1;
        settle_credits("reset credits");
        clear_status("reset credits");
    endtask

    task automatic test_dead_time();
        for (int p = 0; p < NUM_PHASES; p++) begin
            raise_fault(p, int'(FK_DEAD_TIME));
            compare_records("dead_time");
            clear_status("dead_time");
        end
        settle_credits("dead_time");
    endtask

    task automatic test_mismatch_filter();
        for (int p = 0; p < NUM_PHASES; p++) begin
            hold_mismatch(p, MM_FILTER_CYC - 3);
            repeat (20) @(negedge i_clk);
            check_value("mismatch short records", 0, rcv_q.size());
            check_value("mismatch short status", 0, int'(fault_status));
            raise_fault(p, int'(FK_MISMATCH));
            compare_records("mismatch long");
            clear_status("mismatch long");
            hold_mismatch(p, 50);
            expect_event(p, int'(FK_MISMATCH));
            compare_records("mismatch held");
            clear_status("mismatch held");
        end
        settle_credits("mismatch");
    endtask

    // mismatch leads so both kinds reach the reporter together
    task automatic test_priority();
        @(posedge i_clk);
        pwm_cmd <= '1;
        repeat (MM_FILTER_CYC - 1) @(posedge i_clk);
        pwm_dt <= '1;
        repeat (6) @(posedge i_clk);
        pwm_dt <= '0;
        repeat (6) @(posedge i_clk);
        pwm_cmd <= '0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            expect_event(p, int'(FK_DEAD_TIME));
            expect_event(p, int'(FK_MISMATCH));
        end
        compare_records("priority");
        settle_credits("priority");
        clear_status("priority");
    endtask

    task automatic test_back_pressure();
        int order[NUM_SRC];
        // every source once, in reverse priority order
        for (int i = 0; i < NUM_SRC; i++) begin
            order[i] = NUM_SRC - 1 - i;
        end
        crd_en = 1'b0;
        for (int i = 0; i < NUM_SRC; i++) begin
            raise_fault(order[i] / FAULT_KINDS, order[i] % FAULT_KINDS);
            repeat (10) @(posedge i_clk);
        end
        repeat (30) @(negedge i_clk);
        check_value("back_pressure held", MAX_CREDITS, rcv_q.size());
        crd_en = 1'b1;
        compare_records("back_pressure");
        settle_credits("back_pressure");
        clear_status("back_pressure");
    endtask

    task automatic test_random();
        int p;
        int kind;
        crd_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            p = int'(rng_state % NUM_PHASES);
            kind = int'(rng_state[16]);
            raise_fault(p, kind);
            repeat (30) @(posedge i_clk);
        end
        compare_records("random");
        crd_random = 1'b0;
        settle_credits("random");
    endtask

    initial begin
        i_rst_n    = 1'b0;
        pwm_dt     = '0;
        pwm_cmd    = '0;
        pwm_gate   = '0;
        fault_clr  = 1'b0;
        crd_en     = 1'b1;
        crd_random = 1'b0;
        rng_state  = SEED;
        exp_status = 0;
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;
        test_reset_state();
        test_dead_time();
        test_mismatch_filter();
        test_priority();
        test_back_pressure();
        test_random();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- design/fault_event_reporter.sv
//==========================================================================
// fault event reporter
// sticky status, pending capture, priority encode into an event queue,
// queue head released to the consumer under credit flow control
//==========================================================================
`timescale 1ns/10ps

module fault_event_reporter
    import pwm_fault_pkg::*;
#(
    parameter int NUM_PHASES     = DEF_NUM_PHASES,
    parameter int MAX_CREDITS    = DEF_MAX_CREDITS,
    parameter int EVT_FIFO_DEPTH = DEF_EVT_FIFO_DEPTH
)(
    input  logic [NUM_PHASES-1:0]               i_dt_err,
    input  logic [NUM_PHASES-1:0]               i_mm_err,
    input  logic                                i_evt_credit,
    input  logic                                i_fault_clr,

    output logic                                o_evt_valid,
    output logic [phase_idx_w(NUM_PHASES)-1:0]  o_evt_phase,
    output fault_kind_e                         o_evt_kind,
    output logic [FAULT_KINDS*NUM_PHASES-1:0]   o_fault_status,

    input  logic                                i_clk,
    input  logic                                i_rst_n
);

    localparam int NUM_SRC = FAULT_KINDS * NUM_PHASES;
    localparam int PH_W    = phase_idx_w(NUM_PHASES);
    // source index is {phase, kind}
    localparam int SRC_W   = PH_W + 1;
    localparam int QA_W    = (EVT_FIFO_DEPTH > 1) ? $clog2(EVT_FIFO_DEPTH) : 1;
    localparam int QC_W    = $clog2(EVT_FIFO_DEPTH + 1);
    localparam int CR_W    = $clog2(MAX_CREDITS + 1);

    logic [NUM_PHASES-1:0] mm_q;
    logic [NUM_SRC-1:0]    new_fault;
    logic [NUM_SRC-1:0]    pending;
    logic [NUM_SRC-1:0]    take_oh;
    logic                  take_any;
    logic [SRC_W-1:0]      take_src;
    logic                  q_room;
    logic                  push;
    logic                  pop;
    logic [SRC_W-1:0]      q_mem [EVT_FIFO_DEPTH];
    logic [QA_W-1:0]       wr_ptr;
    logic [QA_W-1:0]       rd_ptr;
    logic [QC_W-1:0]       q_count;
    logic [CR_W-1:0]       credits;
    logic [SRC_W-1:0]      head_q;

    //======================================================================
    // fault capture
    //======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mm_q <= '0;
        end else begin
            mm_q <= i_mm_err;
        end
    end

    // dead-time pulses taken as is, mismatch on its rising edge only
    always_comb begin
        for (int p = 0; p < NUM_PHASES; p++) begin
            new_fault[FAULT_KINDS*p]     = i_dt_err[p];
            new_fault[FAULT_KINDS*p + 1] = i_mm_err[p] & ~mm_q[p];
        end
    end

    // a new fault beats a clear in the same cycle;
    // a repeat on a still-pending source merges into it
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_fault_status <= '0;
            pending        <= '0;
        end else begin
            o_fault_status <= (o_fault_status & {NUM_SRC{~i_fault_clr}}) | new_fault;
            pending        <= (pending & ~take_oh) | new_fault;
        end
    end

    //======================================================================
    // priority encode, lowest source index first
    //======================================================================
    always_comb begin
        take_any = 1'b0;
        take_src = '0;
        take_oh  = '0;
        for (int s = NUM_SRC - 1; s >= 0; s--) begin
            if (pending[s]) begin
                take_any = 1'b1;
                take_src = SRC_W'(s);
            end
        end
        if (push) begin
            take_oh[take_src] = 1'b1;
        end
    end

    //======================================================================
    // event queue
    //======================================================================
    // one record still in the output register holds its credit
    assign pop    = (q_count != '0) && (credits > CR_W'(o_evt_valid));
    assign q_room = (q_count != QC_W'(EVT_FIFO_DEPTH)) || pop;
    assign push   = take_any && q_room;

    always_ff @(posedge i_clk) begin
        if (push) begin
            q_mem[wr_ptr] <= take_src;
        end
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QA_W'(EVT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QA_W'(EVT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_count <= q_count + QC_W'(push) - QC_W'(pop);
        end
    end

    //======================================================================
    // credits and output register
    //======================================================================
    // spent on the valid cycle, returned by consumer pulses
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits     <= CR_W'(MAX_CREDITS);
            o_evt_valid <= 1'b0;
        end else begin
            credits     <= credits - CR_W'(o_evt_valid) + CR_W'(i_evt_credit);
            o_evt_valid <= pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) begin
            head_q <= q_mem[rd_ptr];
        end
    end

    assign o_evt_phase = head_q[SRC_W-1:1];
    assign o_evt_kind  = fault_kind_e'(head_q[0]);

    //======================================================================
    // checks
    //======================================================================
    // a record goes out only against a held credit
    a_valid_has_credit: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_evt_valid |-> (credits != '0)
    );

    // consumer never hands back more than it got
    a_credit_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        credits <= CR_W'(MAX_CREDITS)
    );

    a_queue_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        q_count <= QC_W'(EVT_FIFO_DEPTH)
    );

endmodule

//--- design/pwm_fault_monitor.sv
//==========================================================================
// pwm gate-drive fault monitor top level
// input sync, one checker per phase, and the fault event reporter
//==========================================================================
`timescale 1ns/10ps

module pwm_fault_monitor
    import pwm_fault_pkg::*;
#(
    parameter int NUM_PHASES     = DEF_NUM_PHASES,
    parameter int MM_FILTER_CYC  = DEF_MM_FILTER_CYC,
    parameter int MAX_CREDITS    = DEF_MAX_CREDITS,
    parameter int EVT_FIFO_DEPTH = DEF_EVT_FIFO_DEPTH
)(
    // asynchronous lines from the analog front end
    input  logic [NUM_PHASES-1:0]               i_pwm_dt,
    input  logic [NUM_PHASES-1:0]               i_pwm_cmd,
    input  logic [NUM_PHASES-1:0]               i_pwm_gate,

    input  logic                                i_evt_credit,
    input  logic                                i_fault_clr,

    output logic                                o_evt_valid,
    output logic [phase_idx_w(NUM_PHASES)-1:0]  o_evt_phase,
    output fault_kind_e                         o_evt_kind,
    output logic [FAULT_KINDS*NUM_PHASES-1:0]   o_fault_status,

    input  logic                                i_clk,
    input  logic                                i_rst_n
);

    logic [NUM_PHASES-1:0] dt_sync;
    logic [NUM_PHASES-1:0] cmd_sync;
    logic [NUM_PHASES-1:0] gate_sync;
    logic [NUM_PHASES-1:0] dt_err;
    logic [NUM_PHASES-1:0] mm_err;

    pwm_input_sync #(
        .NUM_PHASES (NUM_PHASES)
    ) u_sync (
        .i_pwm_dt    (i_pwm_dt),
        .i_pwm_cmd   (i_pwm_cmd),
        .i_pwm_gate  (i_pwm_gate),
        .o_dt_sync   (dt_sync),
        .o_cmd_sync  (cmd_sync),
        .o_gate_sync (gate_sync),
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n)
    );

    // identical checker on every phase
    for (genvar p = 0; p < NUM_PHASES; p++) begin : g_phase
        pwm_phase_monitor #(
            .MM_FILTER_CYC (MM_FILTER_CYC)
        ) u_mon (
            .i_dt_sync   (dt_sync[p]),
            .i_cmd_sync  (cmd_sync[p]),
            .i_gate_sync (gate_sync[p]),
            .o_dt_err    (dt_err[p]),
            .o_mm_err    (mm_err[p]),
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n)
        );
    end

    fault_event_reporter #(
        .NUM_PHASES     (NUM_PHASES),
        .MAX_CREDITS    (MAX_CREDITS),
        .EVT_FIFO_DEPTH (EVT_FIFO_DEPTH)
    ) u_report (
        .i_dt_err       (dt_err),
        .i_mm_err       (mm_err),
        .i_evt_credit   (i_evt_credit),
        .i_fault_clr    (i_fault_clr),
        .o_evt_valid    (o_evt_valid),
        .o_evt_phase    (o_evt_phase),
        .o_evt_kind     (o_evt_kind),
        .o_fault_status (o_fault_status),
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n)
    );

endmodule

//--- design/pwm_fault_pkg.sv
//==========================================================================
// pwm gate-drive fault monitor shared definitions
// fault kind encoding, default parameter values and field widths
//==========================================================================
package pwm_fault_pkg;

    //======================================================================
    // fault kinds
    //======================================================================
    // within one phase the dead-time source ranks ahead of mismatch,
    // so the encoding doubles as the low bit of the source index
    typedef enum logic {
        FK_DEAD_TIME = 1'b0,
        FK_MISMATCH  = 1'b1
    } fault_kind_e;

    // fault sources per phase, one per kind
    localparam int FAULT_KINDS = 2;

    //======================================================================
    // default parameter values
    //======================================================================
    // phase count of the inverter
    localparam int DEF_NUM_PHASES     = 3;
    // consecutive cmd/gate disagreement cycles before a mismatch fault
    localparam int DEF_MM_FILTER_CYC  = 8;
    // receiver buffer size, credits held after reset
    localparam int DEF_MAX_CREDITS    = 4;
    // event queue entries, at least FAULT_KINDS * phase count
    localparam int DEF_EVT_FIFO_DEPTH = 8;

    //======================================================================
    // field widths
    //======================================================================
    // width of a phase index, never below one bit
    function automatic int phase_idx_w(input int num_phases);
        if (num_phases > 1) begin
            return $clog2(num_phases);
        end
        return 1;
    endfunction

endpackage

//--- design/pwm_input_sync.sv
//==========================================================================
// pwm input synchronizer bank
// two reset-to-zero flops on every dead-time, command and gate line
//==========================================================================
`timescale 1ns/10ps

module pwm_input_sync
    import pwm_fault_pkg::*;
#(
    parameter int NUM_PHASES = DEF_NUM_PHASES
)(
    input  logic [NUM_PHASES-1:0] i_pwm_dt,
    input  logic [NUM_PHASES-1:0] i_pwm_cmd,
    input  logic [NUM_PHASES-1:0] i_pwm_gate,

    output logic [NUM_PHASES-1:0] o_dt_sync,
    output logic [NUM_PHASES-1:0] o_cmd_sync,
    output logic [NUM_PHASES-1:0] o_gate_sync,

    input  logic                  i_clk,
    input  logic                  i_rst_n
);

    // all three input groups handled as one bus
    localparam int LINES = 3 * NUM_PHASES;

    logic [LINES-1:0] async_in;
    // first stage, may go metastable
    logic [LINES-1:0] meta_q;
    // second stage, safe to use in the clock domain
    logic [LINES-1:0] sync_q;

    // packing order: dt low, then cmd, gate on top
    assign async_in = {i_pwm_gate, i_pwm_cmd, i_pwm_dt};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= async_in;
            sync_q <= meta_q;
        end
    end

    //======================================================================
    // unpack per input group
    //======================================================================
    assign o_dt_sync   = sync_q[NUM_PHASES-1:0];
    assign o_cmd_sync  = sync_q[2*NUM_PHASES-1:NUM_PHASES];
    assign o_gate_sync = sync_q[3*NUM_PHASES-1:2*NUM_PHASES];

endmodule

//--- design/pwm_phase_monitor.sv
//==========================================================================
// per-phase gate-drive checker
// dead-time rising-edge detect and filtered command/gate mismatch detect
//==========================================================================
`timescale 1ns/10ps

module pwm_phase_monitor
    import pwm_fault_pkg::*;
#(
    parameter int MM_FILTER_CYC = DEF_MM_FILTER_CYC
)(
    input  logic i_dt_sync,
    input  logic i_cmd_sync,
    input  logic i_gate_sync,

    output logic o_dt_err,
    output logic o_mm_err,

    input  logic i_clk,
    input  logic i_rst_n
);

    // counter only needs to reach the saturation value
    localparam int CNT_W = (MM_FILTER_CYC > 1) ? $clog2(MM_FILTER_CYC) : 1;
    // value held on the MM_FILTER_CYC-th disagreeing cycle
    localparam logic [CNT_W-1:0] CNT_SAT = CNT_W'(MM_FILTER_CYC - 1);

    // previous dead-time level
    logic             dt_q;
    // command and gate disagree this cycle
    logic             wave_diff;
    // consecutive disagreeing cycles, minus one
    logic [CNT_W-1:0] diff_cnt;

    //======================================================================
    // dead-time edge
    //======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dt_q <= 1'b0;
        end else begin
            dt_q <= i_dt_sync;
        end
    end

    // one cycle, on the first high cycle only
    assign o_dt_err = i_dt_sync & ~dt_q;

    //======================================================================
    // mismatch filter
    //======================================================================
    assign wave_diff = i_cmd_sync ^ i_gate_sync;

    // restart on every agreeing cycle, hold at saturation
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            diff_cnt <= '0;
        end else if (!wave_diff) begin
            diff_cnt <= '0;
        end else if (diff_cnt != CNT_SAT) begin
            diff_cnt <= diff_cnt + 1'b1;
        end
    end

    // drops the same cycle the waves agree again
    assign o_mm_err = wave_diff & (diff_cnt == CNT_SAT);

    //======================================================================
    // checks
    //======================================================================
    // a dead-time fault is a single-cycle event
    a_dt_err_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_dt_err |=> !o_dt_err
    );

endmodule

//--- pwm_fault_monitor.f
design/pwm_fault_pkg.sv
design/pwm_input_sync.sv
design/pwm_phase_monitor.sv
design/fault_event_reporter.sv
design/pwm_fault_monitor.sv
bench/tb_pwm_fault_monitor.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pwm fault monitor testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_pwm_fault_monitor \
        -f pwm_fault_monitor.f -o sim_tb > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "PASS: all tests" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
